/* verilog.f */
+incdir+source
source/cpu_pkg.sv
source/cpu_ifs.sv
source/fetch_unit.sv
source/decode_unit.sv
source/execute_unit.sv
source/result_unit.sv
source/cpu.sv
tb/tb_clock_gen.sv
tb/cpu_checker.sv
tb/cpu_tb.sv

/* tb/cpu_tb.sv */
// Testbench top with a random RV32I program in a ROM, an ISA model and per-commit checks
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module cpu_tb;
    localparam int         PROG_WORDS     = 64;
    localparam int         COMMIT_TIMEOUT = 10;
    localparam int         RESET_TIMEOUT  = 20;
    localparam logic [6:0] OP_REG         = 7'b0110011;
    localparam logic [6:0] OP_IMM         = 7'b0010011;
    localparam logic [6:0] OP_LUI         = 7'b0110111;

    logic        clk;
    logic        reset;
    logic [31:0] irom_inst;
    logic [31:0] irom_addr;
    logic        wb_have_inst;
    logic [31:0] wb_pc;
    logic        wb_ena;
    logic [4:0]  wb_reg;
    logic [31:0] wb_value;

    logic [31:0] rom [PROG_WORDS];
    logic [31:0] model_regs [32];
    logic [31:0] rng_state;
    int unsigned error_count;

    tb_clock_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(5)) u_clock_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    cpu dut (
        .clk_cpu              (clk),
        .reset_i              (reset),
        .irom_inst_i          (irom_inst),
        .irom_addr_o          (irom_addr),
        .debug_wb_have_inst_o (wb_have_inst),
        .debug_wb_pc_o        (wb_pc),
        .debug_wb_ena_o       (wb_ena),
        .debug_wb_reg_o       (wb_reg),
        .debug_wb_value_o     (wb_value)
    );

    bind cpu cpu_checker u_cpu_checker (
        .clk_i                (clk_cpu),
        .reset_i              (reset_i),
        .irom_addr_i          (irom_addr_o),
        .debug_wb_have_inst_i (debug_wb_have_inst_o),
        .debug_wb_ena_i       (debug_wb_ena_o)
    );

    // Combinational ROM that reads zero past the end of the program
    always_comb begin
        if (irom_addr < PROG_WORDS * 4) begin
            irom_inst = rom[irom_addr[$clog2(PROG_WORDS)+1:2]];
        end else begin
            irom_inst = 32'h0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Program generation
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Sources stay in x0..x7 so hazards are frequent
    function automatic logic [31:0] random_instruction();
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        logic [6:0]  bad_opc [4];
        r = next_random();
        s = next_random();
        rd  = (s[15:13] == 3'd0) ? s[20:16] : {2'b00, s[2:0]};
        rs1 = {2'b00, s[5:3]};
        rs2 = {2'b00, s[8:6]};
        f3  = r[2:0];
        imm = r[19:8];
        alt = r[20];
        bad_opc = '{7'b0000011, 7'b0100011, 7'b1100011, 7'b1101111};
        if (r[7:4] < 4'd5) begin
            return {(alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                    rs2, rs1, f3, rd, OP_REG};
        end else if (r[7:4] < 4'd11) begin
            if (f3 == 3'b001) begin
                imm = {7'h00, imm[4:0]};
            end else if (f3 == 3'b101) begin
                imm = {1'b0, alt, 5'b00000, imm[4:0]};
            end
            return {imm, rs1, f3, rd, OP_IMM};
        end else if (r[7:4] < 4'd14) begin
            return {r[31:12], rd, OP_LUI};
        end
        return {s[31:7], bad_opc[r[9:8]]};
    endfunction

    // x1..x7 are written first since the register file has no reset
    task automatic fill_program();
        logic [31:0] r;
        for (int k = 1; k < 8; k++) begin
            r = next_random();
            if (k % 2 == 1) begin
                rom[k-1] = {r[31:12], 5'(k), OP_LUI};
            end else begin
                rom[k-1] = {r[11:0], 5'd0, 3'b000, 5'(k), OP_IMM};
            end
        end
        for (int w = 7; w < PROG_WORDS; w++) begin
            rom[w] = random_instruction();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // ISA model
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] shift_right_arith(input logic [31:0] a, input logic [4:0] sh);
        logic [31:0] fill;
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
        return (a >> sh) | fill;
    endfunction

    function automatic logic [31:0] isa_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            // Differing signs decide by the sign bit alone
            3'b010:  return ((a[31] != b[31]) ? a[31] : (a < b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? shift_right_arith(a, b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model_execute(input logic [31:0] inst, output logic ena,
                                 output logic [4:0] rd, output logic [31:0] value);
        logic [31:0] a;
        logic [31:0] b;
        a     = model_regs[inst[19:15]];
        b     = model_regs[inst[24:20]];
        rd    = inst[11:7];
        ena   = 1'b1;
        value = 32'h0;
        case (inst[6:0])
            OP_REG:  value = isa_alu(inst[14:12], inst[30], a, b);
            OP_IMM:  value = isa_alu(inst[14:12], inst[14:12] == 3'b101 && inst[30], a,
                                     {{20{inst[31]}}, inst[31:20]});
            OP_LUI:  value = {inst[31:12], 12'h000};
            default: ena = 1'b0;
        endcase
        if (ena && rd != 5'd0) begin
            model_regs[rd] = value;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Checks and waits
    ////////////////////////////////////////////////////////////
    task automatic check_word(input string name, input int index,
                              input logic [31:0] got, input logic [31:0] expected);
        assert (got === expected) else begin
            $display("[FAIL] commit %0d %s got 0x%h expected 0x%h", index, name, got, expected);
            error_count++;
        end
    endtask

    task automatic wait_commit(output logic seen);
        seen = 1'b0;
        for (int c = 0; c < COMMIT_TIMEOUT && !seen; c++) begin
            @(negedge clk);
            seen = (wb_have_inst === 1'b1);
        end
    endtask

    task automatic wait_reset_release(output logic released);
        released = 1'b0;
        for (int c = 0; c < RESET_TIMEOUT && !released; c++) begin
            @(negedge clk);
            released = (reset === 1'b0);
        end
    endtask

    initial begin
        logic        seen;
        logic        exp_ena;
        logic [4:0]  exp_rd;
        logic [31:0] exp_value;
        logic [31:0] exp_pc;
        int unsigned checker_errors;
        error_count = 0;
        rng_state   = 32'd26;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = 32'h0;
        end
        fill_program();
        wait_reset_release(seen);
        if (!seen) begin
            $display("Reset was never released");
            error_count++;
        end
        for (int i = 0; i < PROG_WORDS && seen; i++) begin
            model_execute(rom[i], exp_ena, exp_rd, exp_value);
            exp_pc = `CPU_RESET_PC + 32'(i * 4);
            wait_commit(seen);
            if (!seen) begin
                $display("Instruction %0d did not commit within %0d cycles", i, COMMIT_TIMEOUT);
                error_count++;
            end else begin
                check_word("debug_wb_pc_o", i, wb_pc, exp_pc);
                check_word("debug_wb_ena_o", i, 32'(wb_ena), 32'(exp_ena));
                if (exp_ena) begin
                    check_word("debug_wb_reg_o", i, 32'(wb_reg), 32'(exp_rd));
                    check_word("debug_wb_value_o", i, wb_value, exp_value);
                end
            end
        end
        checker_errors = dut.u_cpu_checker.fail_count;
        $display("Closing report: %0d check errors, %0d assertion errors",
                 error_count, checker_errors);
        if (error_count == 0 && checker_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/cpu_checker.sv */
// Concurrent assertions on the CPU top-level ports, attached to the DUT with bind
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
    input wire        clk_i,
    input wire        reset_i,
    input wire [31:0] irom_addr_i,
    input wire        debug_wb_have_inst_i,
    input wire        debug_wb_ena_i
);
    int unsigned fail_count = 0;

    ena_needs_commit: assert property (
        @(posedge clk_i) disable iff (reset_i)
        debug_wb_ena_i |-> debug_wb_have_inst_i
    ) else begin
        fail_count++;
        $error("register write flagged without a committed instruction");
    end

    fetch_aligned: assert property (
        @(posedge clk_i) disable iff (reset_i)
        irom_addr_i[1:0] == 2'b00
    ) else begin
        fail_count++;
        $error("fetch address is not word aligned");
    end

    // No branches, so the PC holds or steps by one word
    fetch_step: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !$past(reset_i) |->
            (irom_addr_i == $past(irom_addr_i) || irom_addr_i == $past(irom_addr_i) + 32'd4)
    ) else begin
        fail_count++;
        $error("fetch address moved by something other than 0 or 4");
    end

    quiet_after_reset: assert property (
        @(posedge clk_i)
        $past(reset_i) |-> !debug_wb_have_inst_i
    ) else begin
        fail_count++;
        $error("commit seen in the cycle after reset");
    end

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
// Testbench clock and reset source, instantiated once by the testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic reset_o
);
    int unsigned edge_count;

    initial begin
        clk_o      = 1'b0;
        reset_o    = 1'b1;
        edge_count = 0;
    end

    always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

    // Reset drops on the edge that ends the last reset cycle
    always @(posedge clk_o) begin
        if (edge_count < RESET_CYCLES) begin
            edge_count <= edge_count + 1;
        end
        if (edge_count == RESET_CYCLES - 1) begin
            reset_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/cpu.sv */
// Top level of the RV32I pipeline, connects fetch, decode, execute and result stages
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module cpu (
    input  wire                        clk_cpu,
    input  wire                        reset_i,
    input  wire [`CPU_INST_WIDTH-1:0]  irom_inst_i,
    output cpu_pkg::word_t             irom_addr_o,
    output logic                       debug_wb_have_inst_o,
    output cpu_pkg::word_t             debug_wb_pc_o,
    output logic                       debug_wb_ena_o,
    output cpu_pkg::reg_addr_t         debug_wb_reg_o,
    output cpu_pkg::word_t             debug_wb_value_o
);
    import cpu_pkg::*;

    // Fetch to decode
    inst_u     fd_inst;
    word_t     fd_pc;
    logic      fd_valid;
    logic      stall;

    // Execute to result
    logic      er_valid;
    word_t     er_pc;
    reg_addr_t er_rd;
    logic      er_rf_we;
    word_t     er_result;

    exec_if ex_bus ();
    wb_if   wb_bus ();

    fetch_unit u_fetch (
        .clk_cpu     (clk_cpu),
        .reset_i     (reset_i),
        .stall_i     (stall),
        .irom_inst_i (irom_inst_i),
        .irom_addr_o (irom_addr_o),
        .inst_o      (fd_inst),
        .pc_o        (fd_pc),
        .valid_o     (fd_valid)
    );

    decode_unit u_decode (
        .clk_cpu (clk_cpu),
        .reset_i (reset_i),
        .inst_i  (fd_inst),
        .pc_i    (fd_pc),
        .valid_i (fd_valid),
        .stall_o (stall),
        .ex      (ex_bus.decode_mp),
        .wb      (wb_bus.decode_mp)
    );

    execute_unit u_execute (
        .ex       (ex_bus.execute_mp),
        .valid_o  (er_valid),
        .pc_o     (er_pc),
        .rd_o     (er_rd),
        .rf_we_o  (er_rf_we),
        .result_o (er_result)
    );

    result_unit u_result (
        .clk_cpu              (clk_cpu),
        .reset_i              (reset_i),
        .valid_i              (er_valid),
        .pc_i                 (er_pc),
        .rd_i                 (er_rd),
        .rf_we_i              (er_rf_we),
        .result_i             (er_result),
        .wb                   (wb_bus.result_mp),
        .debug_wb_have_inst_o (debug_wb_have_inst_o),
        .debug_wb_pc_o        (debug_wb_pc_o),
        .debug_wb_ena_o       (debug_wb_ena_o),
        .debug_wb_reg_o       (debug_wb_reg_o),
        .debug_wb_value_o     (debug_wb_value_o)
    );

endmodule

`default_nettype wire

/* source/result_unit.sv */
// Result stage registering each instruction for the register file write and debug commit
`timescale 1ns/1ps
`default_nettype none

module result_unit (
    input  wire                     clk_cpu,
    input  wire                     reset_i,
    input  wire                     valid_i,
    input  wire cpu_pkg::word_t     pc_i,
    input  wire cpu_pkg::reg_addr_t rd_i,
    input  wire                     rf_we_i,
    input  wire cpu_pkg::word_t     result_i,
    wb_if.result_mp                 wb,
    output logic                    debug_wb_have_inst_o,
    output cpu_pkg::word_t          debug_wb_pc_o,
    output logic                    debug_wb_ena_o,
    output cpu_pkg::reg_addr_t      debug_wb_reg_o,
    output cpu_pkg::word_t          debug_wb_value_o
);
    import cpu_pkg::*;

    logic      valid_q;
    logic      we_q;
    word_t     pc_q;
    reg_addr_t rd_q;
    word_t     value_q;

    always_ff @(posedge clk_cpu) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            we_q    <= 1'b0;
        end else begin
            valid_q <= valid_i;
            we_q    <= rf_we_i;
        end
    end

    always_ff @(posedge clk_cpu) begin
        pc_q    <= pc_i;
        rd_q    <= rd_i;
        value_q <= result_i;
    end

    // Register file takes this on the next edge
    assign wb.we    = we_q;
    assign wb.rd    = rd_q;
    assign wb.value = value_q;

    assign debug_wb_have_inst_o = valid_q;
    assign debug_wb_pc_o        = pc_q;
    assign debug_wb_ena_o       = we_q;
    assign debug_wb_reg_o       = rd_q;
    assign debug_wb_value_o     = value_q;

endmodule

`default_nettype wire

/* source/execute_unit.sv */
// Execute stage: combinational ALU whose result goes straight to the result stage
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module execute_unit (
    exec_if.execute_mp          ex,
    output logic                valid_o,
    output cpu_pkg::word_t      pc_o,
    output cpu_pkg::reg_addr_t  rd_o,
    output logic                rf_we_o,
    output cpu_pkg::word_t      result_o
);
    import cpu_pkg::*;

    logic [$clog2(`CPU_XLEN)-1:0] shamt;

    assign shamt = ex.op_b[$clog2(`CPU_XLEN)-1:0];

    always_comb begin
        case (ex.alu_op)
            ALU_ADD:    result_o = ex.rs1_val + ex.op_b;
            ALU_SUB:    result_o = ex.rs1_val - ex.op_b;
            ALU_AND:    result_o = ex.rs1_val & ex.op_b;
            ALU_OR:     result_o = ex.rs1_val | ex.op_b;
            ALU_XOR:    result_o = ex.rs1_val ^ ex.op_b;
            ALU_SLL:    result_o = ex.rs1_val << shamt;
            ALU_SRL:    result_o = ex.rs1_val >> shamt;
            ALU_SRA:    result_o = word_t'($signed(ex.rs1_val) >>> shamt);
            ALU_SLT:    result_o = word_t'($signed(ex.rs1_val) < $signed(ex.op_b));
            ALU_SLTU:   result_o = word_t'(ex.rs1_val < ex.op_b);
            // lui immediate is already in place
            ALU_PASS_B: result_o = ex.op_b;
            default:    result_o = '0;
        endcase
    end

    assign valid_o = ex.valid;
    assign pc_o    = ex.pc;
    assign rd_o    = ex.rd;
    assign rf_we_o = ex.rf_we;

endmodule

`default_nettype wire

/* source/decode_unit.sv */
// Decode stage: field decode, register file, hazard stall and the decode-to-execute register
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module decode_unit (
    input  wire                 clk_cpu,
    input  wire                 reset_i,
    input  wire cpu_pkg::inst_u inst_i,
    input  wire cpu_pkg::word_t pc_i,
    input  wire                 valid_i,
    output logic                stall_o,
    exec_if.decode_mp           ex,
    wb_if.decode_mp             wb
);
    import cpu_pkg::*;

    word_t      regs [`CPU_REG_COUNT];
    logic [6:0] opcode;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    logic       uses_rs1;
    logic       uses_rs2;
    word_t      imm;
    alu_op_e    alu_op;
    logic       rf_we;
    word_t      rs1_val;
    word_t      rs2_val;
    logic       hazard_rs1;
    logic       hazard_rs2;

    // alt_sub only for R-type, alt_shift picks sra/srai
    function automatic alu_op_e alu_decode(input logic [2:0] funct3,
                                           input logic alt_sub,
                                           input logic alt_shift);
        case (funct3)
            F3_ADD_SUB: return alt_sub ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return alt_shift ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Field decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        opcode   = inst_i.r_fmt.opcode;
        rs1      = inst_i.r_fmt.rs1;
        rs2      = inst_i.r_fmt.rs2;
        rd       = inst_i.r_fmt.rd;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        imm      = '0;
        alu_op   = ALU_ADD;
        rf_we    = 1'b0;
        case (opcode)
            OPC_OP: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                rf_we    = 1'b1;
                alu_op   = alu_decode(inst_i.r_fmt.funct3, inst_i.r_fmt.funct7[5],
                                      inst_i.r_fmt.funct7[5]);
            end
            OPC_OP_IMM: begin
                rs1      = inst_i.i_fmt.rs1;
                rd       = inst_i.i_fmt.rd;
                uses_rs1 = 1'b1;
                rf_we    = 1'b1;
                imm      = {{(`CPU_XLEN-12){inst_i.i_fmt.imm12[11]}}, inst_i.i_fmt.imm12};
                alu_op   = alu_decode(inst_i.i_fmt.funct3, 1'b0, inst_i.i_fmt.imm12[10]);
            end
            OPC_LUI: begin
                rd     = inst_i.u_fmt.rd;
                rf_we  = 1'b1;
                imm    = {inst_i.u_fmt.imm20, 12'b0};
                alu_op = ALU_PASS_B;
            end
            default: begin
                // Unsupported, commits without a write
                rf_we = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_cpu) begin
        if (wb.we && wb.rd != '0) begin
            regs[wb.rd] <= wb.value;
        end
    end

    // Same-cycle commit is forwarded to the read
    assign rs1_val = (rs1 == '0) ? '0 :
                     (wb.we && wb.rd == rs1) ? wb.value : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 :
                     (wb.we && wb.rd == rs2) ? wb.value : regs[rs2];

    // Producer still in execute
    assign hazard_rs1 = uses_rs1 && rs1 != '0 && rs1 == ex.rd;
    assign hazard_rs2 = uses_rs2 && rs2 != '0 && rs2 == ex.rd;
    assign stall_o    = valid_i && ex.valid && ex.rf_we && (hazard_rs1 || hazard_rs2);

    ////////////////////////////////////////////////////////////
    // Decode-to-execute register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_cpu) begin
        if (reset_i) begin
            ex.valid <= 1'b0;
            ex.rf_we <= 1'b0;
        end else begin
            ex.valid <= valid_i && !stall_o;
            ex.rf_we <= valid_i && !stall_o && rf_we;
        end
    end

    always_ff @(posedge clk_cpu) begin
        ex.pc      <= pc_i;
        ex.rs1_val <= rs1_val;
        ex.op_b    <= uses_rs2 ? rs2_val : imm;
        ex.alu_op  <= alu_op;
        ex.rd      <= rd;
    end

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
// Fetch stage: program counter and the fetch register that feeds decode
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module fetch_unit (
    input  wire                 clk_cpu,
    input  wire                 reset_i,
    input  wire                 stall_i,
    input  wire cpu_pkg::inst_u irom_inst_i,
    output cpu_pkg::word_t      irom_addr_o,
    output cpu_pkg::inst_u      inst_o,
    output cpu_pkg::word_t      pc_o,
    output logic                valid_o
);
    import cpu_pkg::*;

    word_t pc_q;

    // ROM is combinational, the PC is the address
    assign irom_addr_o = pc_q;

    always_ff @(posedge clk_cpu) begin
        if (reset_i) begin
            pc_q <= `CPU_RESET_PC;
        end else if (!stall_i) begin
            pc_q <= pc_q + word_t'(4);
        end
    end

    // Low only until the first word is captured
    always_ff @(posedge clk_cpu) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else if (!stall_i) begin
            valid_o <= 1'b1;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (!stall_i) begin
            inst_o <= irom_inst_i;
            pc_o   <= pc_q;
        end
    end

endmodule

`default_nettype wire

/* source/cpu_ifs.sv */
// Stage interfaces: decoded operands into execute, and the commit back to the register file
`timescale 1ns/1ps
`default_nettype none

interface exec_if;
    import cpu_pkg::*;

    logic      valid;
    word_t     pc;
    word_t     rs1_val;
    word_t     op_b;
    alu_op_e   alu_op;
    reg_addr_t rd;
    logic      rf_we;

    modport decode_mp (output valid, pc, rs1_val, op_b, alu_op, rd, rf_we);
    modport execute_mp (input valid, pc, rs1_val, op_b, alu_op, rd, rf_we);
endinterface

interface wb_if;
    import cpu_pkg::*;

    logic      we;
    reg_addr_t rd;
    word_t     value;

    modport result_mp (output we, rd, value);
    modport decode_mp (input we, rd, value);
endinterface

`default_nettype wire

/* source/cpu_pkg.sv */
// Shared types and RV32I encodings, imported by every stage of the pipeline
`default_nettype none
`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_addr_t;

    ////////////////////////////////////////////////////////////
    // Instruction formats
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [`CPU_INST_WIDTH-1:12] imm20;
        reg_addr_t                   rd;
        logic [6:0]                  opcode;
    } u_fmt_t;

    // One fetched word, seen through the format its opcode selects
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        u_fmt_t u_fmt;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    // Opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // Funct3, shared by R and I type
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

endpackage

`default_nettype wire

/* source/cpu_settings.svh */
// Global widths and reset PC of the pipeline, included by the package and the RTL
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath and register file
`define CPU_XLEN        32
`define CPU_REG_COUNT   32
`define CPU_INST_WIDTH  32

// First fetch address after reset
`define CPU_RESET_PC    32'h0000_0000

`endif
